// File: dnc_write_interface.f
rtl/dnc_write_pkg.sv
rtl/dnc_write_vector.sv
rtl/dnc_erase_vector.sv
rtl/dnc_write_strength.sv
rtl/dnc_write_interface.sv
dv/tb_dnc_write_interface.sv

// File: Makefile
# Verilator build for the DNC write-head output stage
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_dnc_write_interface
FILELIST  ?= dnc_write_interface.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal, the status comes from the pass search
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_dnc_write_interface.sv
/* Directed tests at FRACT_SIZE 8, expected values come from local reference models
   Every test starts from reset, so no stream is left running between tests */
`timescale 1ns/1ns

module tb_dnc_write_interface
  import dnc_write_pkg::*;
;

  localparam int FRACT_SIZE = 8;
  // Rough length of each test in cycles, summed
  localparam int TEST_CYCLES    = 30 + 20 + 40 + 25 + 60 + 35;
  localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;
  localparam int READY_WAIT     = 40;

  logic   CLK = 1'b0;
  logic   RST;
  logic   START;
  index_t SIZE_W_IN;
  logic   V_IN_ENABLE, E_IN_ENABLE, BETA_IN_ENABLE;
  data_t  V_IN, E_IN, BETA_IN;
  logic   V_OUT_ENABLE, E_OUT_ENABLE, BETA_OUT_ENABLE;
  logic   V_READY, E_READY, BETA_READY;
  data_t  V_OUT, E_OUT, BETA_OUT;

  // Expected output elements, in order
  data_t  exp_v[$];
  data_t  exp_e[$];
  data_t  exp_b[$];
  // Elements seen since the last READY, and READY pulses seen so far
  index_t cnt_v = '0, cnt_e = '0, cnt_b = '0;
  int     v_ready_cnt = 0, e_ready_cnt = 0, b_ready_cnt = 0;
  int     base_v, base_e, base_b;
  index_t w_cur = '0;
  integer seed = 32'h33e4;
  int     errors_data = 0, errors_count = 0, errors_other = 0;
  int     cycle_count = 0;
  int     total;

  dnc_write_interface #(
    .FRACT_SIZE (FRACT_SIZE)
  ) i_dnc_write_interface (
    .CLK (CLK), .RST (RST), .START (START), .SIZE_W_IN (SIZE_W_IN),
    .V_IN_ENABLE (V_IN_ENABLE), .V_IN (V_IN), .V_OUT_ENABLE (V_OUT_ENABLE),
    .V_OUT (V_OUT), .V_READY (V_READY),
    .E_IN_ENABLE (E_IN_ENABLE), .E_IN (E_IN), .E_OUT_ENABLE (E_OUT_ENABLE),
    .E_OUT (E_OUT), .E_READY (E_READY),
    .BETA_IN_ENABLE (BETA_IN_ENABLE), .BETA_IN (BETA_IN),
    .BETA_OUT_ENABLE (BETA_OUT_ENABLE), .BETA_OUT (BETA_OUT), .BETA_READY (BETA_READY)
  );

  always #10 CLK = ~CLK;

  ////////////////////
  // Reference models
  ////////////////////

  // clamp(1/2 + x/4, 0, 1), x/4 rounds toward minus infinity
  function automatic data_t hard_logistic(input data_t x);
    int s;
    s = (int'(x) >>> 2) + (1 << (FRACT_SIZE - 1));
    if (s < 0) s = 0;
    else if (s > (1 << FRACT_SIZE)) s = 1 << FRACT_SIZE;
    return data_t'(s);
  endfunction

  // 1 + max(x, 0), saturating at the largest positive element
  function automatic data_t hard_oneplus(input data_t x);
    int s;
    s = (1 << FRACT_SIZE) + ((x > 0) ? int'(x) : 0);
    if (s > (1 << (DATA_W - 1)) - 1) s = (1 << (DATA_W - 1)) - 1;
    return data_t'(s);
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic compare_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %0d, expected %0d", $time, what, got, exp);
      errors_data++;
    end
  endtask

  task automatic compare_count(input index_t got, input index_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %0d, expected %0d", $time, what, got, exp);
      errors_count++;
    end
  endtask

  ////////////////////
  // Output monitor
  ////////////////////

  // Sampled on the falling edge, half a cycle away from any change
  always @(negedge CLK) begin
    if (RST) begin
      cnt_v = '0;
      cnt_e = '0;
      cnt_b = '0;
    end
    if (V_OUT_ENABLE) begin
      if (exp_v.size() == 0) begin
        $display("ERROR at %0t: V_OUT element that no input asked for", $time);
        errors_other++;
      end else compare_data(V_OUT, exp_v.pop_front(), "V_OUT");
      cnt_v++;
    end
    if (V_READY) begin
      if (!V_OUT_ENABLE) begin
        $display("ERROR at %0t: V_READY came without the last V_OUT_ENABLE", $time);
        errors_other++;
      end
      compare_count(cnt_v, w_cur, "V_OUT element count");
      cnt_v = '0;
      v_ready_cnt++;
    end
    if (E_OUT_ENABLE) begin
      if (exp_e.size() == 0) begin
        $display("ERROR at %0t: E_OUT element that no input asked for", $time);
        errors_other++;
      end else compare_data(E_OUT, exp_e.pop_front(), "E_OUT");
      cnt_e++;
    end
    if (E_READY) begin
      if (!E_OUT_ENABLE) begin
        $display("ERROR at %0t: E_READY came without the last E_OUT_ENABLE", $time);
        errors_other++;
      end
      compare_count(cnt_e, w_cur, "E_OUT element count");
      cnt_e = '0;
      e_ready_cnt++;
    end
    if (BETA_OUT_ENABLE) begin
      if (exp_b.size() == 0) begin
        $display("ERROR at %0t: BETA_OUT element that no input asked for", $time);
        errors_other++;
      end else compare_data(BETA_OUT, exp_b.pop_front(), "BETA_OUT");
      cnt_b++;
    end
    if (BETA_READY) begin
      if (!BETA_OUT_ENABLE) begin
        $display("ERROR at %0t: BETA_READY came without BETA_OUT_ENABLE", $time);
        errors_other++;
      end
      compare_count(cnt_b, index_t'(1), "BETA_OUT element count");
      cnt_b = '0;
      b_ready_cnt++;
    end
  end

  // Hard limit on the run
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////
  // Drive helpers
  ////////////////////

  // Inputs change 2 ns after the rising edge
  task automatic next_cycle;
    @(posedge CLK);
    #2;
  endtask

  task automatic clear_inputs;
    START          = 1'b0;
    SIZE_W_IN      = '0;
    V_IN_ENABLE    = 1'b0;
    E_IN_ENABLE    = 1'b0;
    BETA_IN_ENABLE = 1'b0;
    V_IN           = '0;
    E_IN           = '0;
    BETA_IN        = '0;
  endtask

  task automatic apply_reset;
    clear_inputs;
    RST = 1'b1;
    repeat (4) next_cycle;
    exp_v.delete();
    exp_e.delete();
    exp_b.delete();
    RST = 1'b0;
  endtask

  // One START pulse, W held until the next call
  task automatic start_run(input int w);
    base_v    = v_ready_cnt;
    base_e    = e_ready_cnt;
    base_b    = b_ready_cnt;
    w_cur     = index_t'(w);
    SIZE_W_IN = index_t'(w);
    START     = 1'b1;
    next_cycle;
    START = 1'b0;
  endtask

  // Random elements on each stream, with random gaps if asked
  task automatic drive_streams(input int n_v, input int n_e, input int n_b, input bit gaps);
    data_t x;
    while (n_v > 0 || n_e > 0 || n_b > 0) begin
      if (n_v > 0 && (!gaps || ($random(seed) & 1) != 0)) begin
        x = data_t'($random(seed));
        exp_v.push_back(x);
        V_IN        = x;
        V_IN_ENABLE = 1'b1;
        n_v--;
      end
      if (n_e > 0 && (!gaps || ($random(seed) & 1) != 0)) begin
        x = data_t'($random(seed));
        exp_e.push_back(hard_logistic(x));
        E_IN        = x;
        E_IN_ENABLE = 1'b1;
        n_e--;
      end
      if (n_b > 0 && (!gaps || ($random(seed) & 1) != 0)) begin
        x = data_t'($random(seed));
        exp_b.push_back(hard_oneplus(x));
        BETA_IN        = x;
        BETA_IN_ENABLE = 1'b1;
        n_b--;
      end
      next_cycle;
      V_IN_ENABLE    = 1'b0;
      E_IN_ENABLE    = 1'b0;
      BETA_IN_ENABLE = 1'b0;
    end
  endtask

  // READY pulses counted from the last START, then a short drain
  task automatic wait_ready(input int want_v, input int want_e, input int want_b);
    int n;
    n = 0;
    while ((v_ready_cnt - base_v < want_v || e_ready_cnt - base_e < want_e ||
            b_ready_cnt - base_b < want_b) && n < READY_WAIT) begin
      next_cycle;
      n++;
    end
    if (v_ready_cnt - base_v < want_v || e_ready_cnt - base_e < want_e ||
        b_ready_cnt - base_b < want_b) begin
      $display("ERROR at %0t: a READY pulse never arrived", $time);
      errors_other++;
    end
    repeat (2) next_cycle;
    if (v_ready_cnt - base_v > want_v || e_ready_cnt - base_e > want_e ||
        b_ready_cnt - base_b > want_b) begin
      $display("ERROR at %0t: more READY pulses than runs", $time);
      errors_other++;
    end
    if (exp_v.size() != 0 || exp_e.size() != 0 || exp_b.size() != 0) begin
      $display("ERROR at %0t: expected output elements never appeared", $time);
      errors_other++;
    end
  endtask

  // All strobes low and data cleared
  task automatic check_quiet;
    @(negedge CLK);
    if (V_OUT_ENABLE || E_OUT_ENABLE || BETA_OUT_ENABLE || V_READY || E_READY ||
        BETA_READY) begin
      $display("ERROR at %0t: output enable or READY high around reset", $time);
      errors_other++;
    end
    compare_data(V_OUT, data_t'(0), "V_OUT after reset");
    compare_data(E_OUT, data_t'(0), "E_OUT after reset");
    compare_data(BETA_OUT, data_t'(0), "BETA_OUT after reset");
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic stream_write_vector;
    apply_reset;
    start_run(6);
    drive_streams(6, 0, 0, 1'b1);
    wait_ready(1, 0, 0);
  endtask

  // Saturated ends, both quarter points and the midpoint
  task automatic erase_corner_values;
    data_t corners [7];
    corners = '{data_t'(-32000), data_t'(-(1 << (FRACT_SIZE - 2))), data_t'(0),
                data_t'(1 << (FRACT_SIZE - 2)), data_t'(32000), data_t'(16'h7fff),
                data_t'(16'h8000)};
    apply_reset;
    start_run(7);
    for (int i = 0; i < 7; i++) begin
      exp_e.push_back(hard_logistic(corners[i]));
      E_IN        = corners[i];
      E_IN_ENABLE = 1'b1;
      next_cycle;
    end
    E_IN_ENABLE = 1'b0;
    wait_ready(0, 1, 0);
  endtask

  // One element per START
  task automatic write_strength_values;
    data_t betas [4];
    betas = '{data_t'(-300), data_t'(0), data_t'(5), data_t'(16'h7fff)};
    apply_reset;
    for (int i = 0; i < 4; i++) begin
      start_run(1);
      exp_b.push_back(hard_oneplus(betas[i]));
      BETA_IN        = betas[i];
      BETA_IN_ENABLE = 1'b1;
      next_cycle;
      BETA_IN_ENABLE = 1'b0;
      wait_ready(0, 0, 1);
    end
  endtask

  task automatic run_all_streams;
    apply_reset;
    start_run(5);
    drive_streams(5, 5, 1, 1'b1);
    wait_ready(1, 1, 1);
  endtask

  task automatic control_edge_cases;
    apply_reset;
    // Strobes while idle give nothing
    V_IN_ENABLE    = 1'b1;
    E_IN_ENABLE    = 1'b1;
    BETA_IN_ENABLE = 1'b1;
    repeat (3) next_cycle;
    V_IN_ENABLE    = 1'b0;
    E_IN_ENABLE    = 1'b0;
    BETA_IN_ENABLE = 1'b0;
    repeat (2) next_cycle;
    // Second START inside a run, must not restart the count
    start_run(4);
    drive_streams(2, 0, 0, 1'b0);
    START = 1'b1;
    drive_streams(1, 0, 0, 1'b0);
    START = 1'b0;
    drive_streams(1, 0, 0, 1'b0);
    wait_ready(1, 0, 0);
    // Strobe after READY, block is idle again
    V_IN_ENABLE = 1'b1;
    next_cycle;
    V_IN_ENABLE = 1'b0;
    repeat (2) next_cycle;
    // Back-to-back runs
    apply_reset;
    start_run(1);
    drive_streams(1, 1, 0, 1'b0);
    wait_ready(1, 1, 0);
    start_run(9);
    drive_streams(9, 9, 0, 1'b0);
    wait_ready(1, 1, 0);
  endtask

  task automatic reset_mid_run;
    apply_reset;
    start_run(8);
    drive_streams(3, 3, 0, 1'b0);
    // Reset hits while the third element sits on the outputs
    RST = 1'b1;
    exp_v.delete();
    exp_e.delete();
    exp_b.delete();
    check_quiet;
    next_cycle;
    RST = 1'b0;
    check_quiet;
    next_cycle;
    start_run(3);
    drive_streams(3, 3, 1, 1'b1);
    wait_ready(1, 1, 1);
  endtask

  ////////////////////
  // Main
  ////////////////////

  initial begin
    clear_inputs;
    RST = 1'b1;
    stream_write_vector;
    erase_corner_values;
    write_strength_values;
    run_all_streams;
    control_edge_cases;
    reset_mid_run;
    total = errors_data + errors_count + errors_other;
    $display("Errors: data %0d, count %0d, other %0d", errors_data, errors_count,
             errors_other);
    if (total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_dnc_write_interface

// File: rtl/dnc_write_interface.sv
/* The three READY pulses are independent, the caller waits on all of them
   SIZE_W_IN must be 1 or more and stable from START until the last READY */
`timescale 1ns/1ns

module dnc_write_interface
  import dnc_write_pkg::*;
#(
  parameter int FRACT_SIZE = 8
) (
  // Global
  input  logic   CLK,
  input  logic   RST,

  // Common control
  input  logic   START,
  input  index_t SIZE_W_IN,

  // Write vector
  input  logic   V_IN_ENABLE,
  input  data_t  V_IN,
  output logic   V_OUT_ENABLE,
  output data_t  V_OUT,
  output logic   V_READY,

  // Erase vector
  input  logic   E_IN_ENABLE,
  input  data_t  E_IN,
  output logic   E_OUT_ENABLE,
  output data_t  E_OUT,
  output logic   E_READY,

  // Write strength
  input  logic   BETA_IN_ENABLE,
  input  data_t  BETA_IN,
  output logic   BETA_OUT_ENABLE,
  output data_t  BETA_OUT,
  output logic   BETA_READY
);

  ////////////////////
  // Write vector, pass-through
  ////////////////////

  dnc_write_vector i_dnc_write_vector (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (V_READY),
    .V_IN_ENABLE  (V_IN_ENABLE),
    .V_OUT_ENABLE (V_OUT_ENABLE),
    .SIZE_W_IN    (SIZE_W_IN),
    .V_IN         (V_IN),
    .V_OUT        (V_OUT)
  );

  ////////////////////
  // Erase vector, hard logistic
  ////////////////////

  dnc_erase_vector #(
    .FRACT_SIZE (FRACT_SIZE)
  ) i_dnc_erase_vector (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (E_READY),
    .E_IN_ENABLE  (E_IN_ENABLE),
    .E_OUT_ENABLE (E_OUT_ENABLE),
    .SIZE_W_IN    (SIZE_W_IN),
    .E_IN         (E_IN),
    .E_OUT        (E_OUT)
  );

  ////////////////////
  // Write strength, hard oneplus
  ////////////////////

  dnc_write_strength #(
    .FRACT_SIZE (FRACT_SIZE)
  ) i_dnc_write_strength (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .READY           (BETA_READY),
    .BETA_IN_ENABLE  (BETA_IN_ENABLE),
    .BETA_OUT_ENABLE (BETA_OUT_ENABLE),
    .BETA_IN         (BETA_IN),
    .BETA_OUT        (BETA_OUT)
  );

endmodule : dnc_write_interface

// File: rtl/dnc_write_strength.sv
/* Hard oneplus beta = 1 + max(x, 0), saturating at the largest data_t value
   One element per START, FRACT_SIZE from 2 to 14 fraction bits */
`timescale 1ns/1ns

module dnc_write_strength
  import dnc_write_pkg::*;
#(
  parameter int FRACT_SIZE = 8
) (
  // Global
  input  logic  CLK,
  input  logic  RST,

  // Control
  input  logic  START,
  output logic  READY,
  input  logic  BETA_IN_ENABLE,
  output logic  BETA_OUT_ENABLE,

  // Data
  input  data_t BETA_IN,
  output data_t BETA_OUT
);

  ////////////////////
  // Constants
  ////////////////////

  // One guard bit catches the carry out of the positive sum
  typedef logic signed [DATA_W:0] wide_t;

  localparam wide_t ONE     = wide_t'(1) << FRACT_SIZE;
  localparam wide_t MAX_POS = wide_t'((2 ** (DATA_W - 1)) - 1);

  ////////////////////
  // Signals
  ////////////////////

  stream_state_t state;

  logic  accept;
  wide_t sum;
  data_t oneplus;

  ////////////////////
  // Body
  ////////////////////

  assign accept = (state == ST_RUN) && BETA_IN_ENABLE;

  // Negative and zero inputs give exactly one
  always_comb begin
    if (BETA_IN > 0) begin
      sum = ONE + wide_t'(BETA_IN);
    end else begin
      sum = ONE;
    end
    oneplus = (sum > MAX_POS) ? data_t'(MAX_POS) : sum[DATA_W-1:0];
  end

  // Single element, so completion coincides with the output strobe
  assign READY = BETA_OUT_ENABLE;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= ST_IDLE;
      BETA_OUT        <= '0;
      BETA_OUT_ENABLE <= 1'b0;
    end else begin
      BETA_OUT_ENABLE <= accept;

      if (accept) begin
        BETA_OUT <= oneplus;
      end

      case (state)
        ST_IDLE: begin
          if (START) begin
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          // First strobe ends the run
          if (BETA_IN_ENABLE) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule : dnc_write_strength

// File: rtl/dnc_erase_vector.sv
/* Hard logistic e = clamp(1/2 + x/4, 0, 1), FRACT_SIZE from 2 to 14 fraction bits
   SIZE_W_IN must be 1 or more and stable for the run, there is no back-pressure */
`timescale 1ns/1ns

module dnc_erase_vector
  import dnc_write_pkg::*;
#(
  parameter int FRACT_SIZE = 8
) (
  // Global
  input  logic   CLK,
  input  logic   RST,

  // Control
  input  logic   START,
  output logic   READY,
  input  logic   E_IN_ENABLE,
  output logic   E_OUT_ENABLE,

  // Data
  input  index_t SIZE_W_IN,
  input  data_t  E_IN,
  output data_t  E_OUT
);

  ////////////////////
  // Constants
  ////////////////////

  // Two guard bits so the sum never wraps before the clamp
  typedef logic signed [DATA_W+1:0] wide_t;

  localparam wide_t HALF = wide_t'(1) << (FRACT_SIZE - 1);
  localparam wide_t ONE  = wide_t'(1) << FRACT_SIZE;

  ////////////////////
  // Signals
  ////////////////////

  // Control FSM
  stream_state_t state;

  // Element counter, runs 0 to W-1
  index_t index_loop;
  index_t last_index;

  logic accept;
  logic last_element;

  // Squash datapath
  wide_t scaled;
  wide_t sum;
  data_t squashed;

  ////////////////////
  // Body
  ////////////////////

  assign last_index   = SIZE_W_IN - index_t'(1);
  assign accept       = (state == ST_RUN) && E_IN_ENABLE;
  assign last_element = (index_loop == last_index);

  // Quarter slope through one half, then clamp to [0, 1]
  always_comb begin
    scaled = wide_t'(E_IN >>> 2);  // sign extends
    sum    = scaled + HALF;
    if (sum < 0) begin
      squashed = '0;
    end else if (sum > ONE) begin
      squashed = data_t'(ONE);
    end else begin
      squashed = sum[DATA_W-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= ST_IDLE;
      index_loop   <= '0;
      E_OUT        <= '0;
      E_OUT_ENABLE <= 1'b0;
      READY        <= 1'b0;
    end else begin
      // Output strobe drops right after the block stops taking input
      E_OUT_ENABLE <= accept;
      READY        <= accept && last_element;

      if (accept) begin
        E_OUT <= squashed;
      end

      case (state)
        ST_IDLE: begin
          if (START) begin
            index_loop <= '0;
            state      <= ST_RUN;
          end
        end
        ST_RUN: begin
          // Count elements, back to idle after element W
          if (E_IN_ENABLE) begin
            if (last_element) begin
              state <= ST_IDLE;
            end else begin
              index_loop <= index_loop + index_t'(1);
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule : dnc_erase_vector

// File: rtl/dnc_write_vector.sv
/* SIZE_W_IN must be 1 or more and held stable for the whole run
   No back-pressure, each V_OUT element must be taken while V_OUT_ENABLE is high */
`timescale 1ns/1ns

module dnc_write_vector
  import dnc_write_pkg::*;
(
  // Global
  input  logic   CLK,
  input  logic   RST,

  // Control
  input  logic   START,
  output logic   READY,
  input  logic   V_IN_ENABLE,
  output logic   V_OUT_ENABLE,

  // Data
  input  index_t SIZE_W_IN,
  input  data_t  V_IN,
  output data_t  V_OUT
);

  ////////////////////
  // Signals
  ////////////////////

  // Control FSM
  stream_state_t state;

  // Element counter, runs 0 to W-1
  index_t index_loop;
  index_t last_index;

  // Element taken this cycle
  logic accept;
  logic last_element;

  ////////////////////
  // Body
  ////////////////////

  assign last_index   = SIZE_W_IN - index_t'(1);
  assign accept       = (state == ST_RUN) && V_IN_ENABLE;
  assign last_element = (index_loop == last_index);

  // v(t;k) = v^(t;k), one cycle of latency
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= ST_IDLE;
      index_loop   <= '0;
      V_OUT        <= '0;
      V_OUT_ENABLE <= 1'b0;
      READY        <= 1'b0;
    end else begin
      // Strobes follow the accept of the previous cycle only
      V_OUT_ENABLE <= accept;
      READY        <= accept && last_element;

      // Output register holds the last element until the next one
      if (accept) begin
        V_OUT <= V_IN;
      end

      case (state)
        ST_IDLE: begin
          // Enables are ignored here
          if (START) begin
            index_loop <= '0;
            state      <= ST_RUN;
          end
        end
        ST_RUN: begin
          // START ignored while running
          if (V_IN_ENABLE) begin
            if (last_element) begin
              state <= ST_IDLE;
            end else begin
              index_loop <= index_loop + index_t'(1);
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule : dnc_write_vector

// File: rtl/dnc_write_pkg.sv
/* Element format and control types shared by the write-head output stage
   Data is signed fixed point, the fraction width is a module parameter */

package dnc_write_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Every element on every stream has this width
  localparam int DATA_W = 16;

  // Element counters and the W size input
  // W may range from 1 to 255, and 0 is not supported
  localparam int INDEX_W = 8;

  ////////////////////
  // Types
  ////////////////////

  // One fixed-point element, two's complement
  typedef logic signed [DATA_W-1:0] data_t;

  // Element count or element index
  typedef logic [INDEX_W-1:0] index_t;

  // Control FSM used by every stream block
  // ST_IDLE waits for START, ST_RUN accepts elements until done
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } stream_state_t;

endpackage : dnc_write_pkg
